// File: dv/tb_wb_backend.sv
`timescale 1ns/1ps

module tb_wb_backend;
    import wb_pkg::*;

    logic        clk;
    logic        resetn;
    logic        in_valid;
    mem_to_wb_t  in_pkt;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    rf_write_t   wb_fwd;
    logic [31:0] trace_pc;
    logic [3:0]  trace_we;
    logic [4:0]  trace_wnum;
    logic [31:0] trace_wdata;
    logic        flush;
    logic [31:0] flush_target;

    integer errors;
    integer seed;

    // reference state of the back end
    logic        hold_valid;
    mem_to_wb_t  hold_pkt;
    logic [31:0] sh_rf [32];
    logic [31:0] known;        // registers written since reset
    logic [31:0] sh_crmd, sh_prmd, sh_estat, sh_era, sh_eentry, sh_tid;
    logic [31:0] sh_save [4];

    logic        exp_ex, exp_ertn, exp_flush, exp_we;
    logic [31:0] exp_target, exp_csr, exp_wdata;
    logic [13:0] rd_num;
    logic        rd1_ok, rd2_ok;

    wb_backend_top dut (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_pkt       (in_pkt),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .wb_fwd       (wb_fwd),
        .trace_pc     (trace_pc),
        .trace_we     (trace_we),
        .trace_wnum   (trace_wnum),
        .trace_wdata  (trace_wdata),
        .flush        (flush),
        .flush_target (flush_target)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // per bit merge of a csr write
    function automatic logic [31:0] masked(input logic [31:0] old, input logic [31:0] mask,
                                           input logic [31:0] value, input logic [31:0] field);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 32; b++) begin
            if (field[b] && mask[b]) res[b] = value[b];
        end
        return res;
    endfunction

    function automatic logic [5:0] prio_ecode(input excep_t e);
        if (e.intr) return 6'h00;
        if (e.adef) return 6'h08;
        if (e.syscall) return 6'h0b;
        if (e.brk) return 6'h0c;
        if (e.ine) return 6'h0d;
        return 6'h09;     // ale
    endfunction

    always_comb begin
        exp_ex     = hold_valid & hold_pkt.excep.any;
        exp_ertn   = hold_valid & hold_pkt.ertn;
        exp_flush  = exp_ex | exp_ertn;
        exp_target = exp_ex ? sh_eentry : sh_era;
        exp_we     = hold_valid & hold_pkt.rf_we & ~hold_pkt.excep.any;
        rd_num     = hold_pkt.read_tid ? 14'h40 : hold_pkt.csr_num;
        case (rd_num)
            14'h00:  exp_csr = sh_crmd;
            14'h01:  exp_csr = sh_prmd;
            14'h05:  exp_csr = sh_estat;
            14'h06:  exp_csr = sh_era;
            14'h0c:  exp_csr = sh_eentry;
            14'h30:  exp_csr = sh_save[0];
            14'h31:  exp_csr = sh_save[1];
            14'h32:  exp_csr = sh_save[2];
            14'h33:  exp_csr = sh_save[3];
            14'h40:  exp_csr = sh_tid;
            default: exp_csr = 32'h0;
        endcase
        exp_wdata = (hold_pkt.csr_re | hold_pkt.read_tid) ? exp_csr : hold_pkt.rf_wdata;
        rd1_ok = (raddr1 == 5'd0) ? (rdata1 == 32'h0) : (!known[raddr1] || rdata1 == sh_rf[raddr1]);
        rd2_ok = (raddr2 == 5'd0) ? (rdata2 == 32'h0) : (!known[raddr2] || rdata2 == sh_rf[raddr2]);
    end

    always @(posedge clk) begin
        if (!resetn) begin
            hold_valid <= 1'b0;
            known      <= '0;
            sh_crmd    <= 32'h8;
            sh_prmd    <= '0;
            sh_estat   <= '0;
            sh_era     <= '0;
            sh_eentry  <= '0;
            sh_tid     <= '0;
            for (int k = 0; k < 4; k++) sh_save[k] <= '0;
        end else begin
            if (exp_we && hold_pkt.rf_waddr != 5'd0) begin
                sh_rf[hold_pkt.rf_waddr] <= exp_wdata;
                known[hold_pkt.rf_waddr] <= 1'b1;
            end
            if (exp_ex) begin
                sh_prmd[2:0]    <= sh_crmd[2:0];   // pie, pplv
                sh_crmd[2:0]    <= 3'b000;
                sh_estat[21:16] <= prio_ecode(hold_pkt.excep);
                sh_estat[30:22] <= hold_pkt.esubcode;
                sh_era          <= hold_pkt.pc;
            end else if (exp_ertn) begin
                sh_crmd[2:0] <= sh_prmd[2:0];
            end else if (hold_valid && hold_pkt.csr_we) begin
                case (hold_pkt.csr_num)
                    14'h00: sh_crmd <= masked(sh_crmd, hold_pkt.csr_wmask, hold_pkt.csr_wvalue,
                                              32'h0000_01ff);
                    14'h01: sh_prmd <= masked(sh_prmd, hold_pkt.csr_wmask, hold_pkt.csr_wvalue,
                                              32'h0000_0007);
                    14'h05: sh_estat <= masked(sh_estat, hold_pkt.csr_wmask, hold_pkt.csr_wvalue,
                                               32'h0000_0003);
                    14'h06: sh_era <= masked(sh_era, hold_pkt.csr_wmask, hold_pkt.csr_wvalue,
                                             32'hffff_ffff);
                    14'h0c: sh_eentry <= masked(sh_eentry, hold_pkt.csr_wmask,
                                                hold_pkt.csr_wvalue, 32'hffff_ffc0);
                    14'h30, 14'h31, 14'h32, 14'h33:
                        sh_save[hold_pkt.csr_num[1:0]] <= masked(sh_save[hold_pkt.csr_num[1:0]],
                            hold_pkt.csr_wmask, hold_pkt.csr_wvalue, 32'hffff_ffff);
                    14'h40: sh_tid <= masked(sh_tid, hold_pkt.csr_wmask, hold_pkt.csr_wvalue,
                                             32'hffff_ffff);
                    default: ;
                endcase
            end
            hold_valid <= in_valid && !exp_flush;    // younger packet dropped on flush
            if (in_valid && !exp_flush) hold_pkt <= in_pkt;
        end
    end

    // sampled on the falling edge when inputs and outputs are settled
    flush_chk: assert property (@(negedge clk) disable iff (!resetn) flush == exp_flush)
        else begin
            $display("MISMATCH %0t: flush %b, expected %b", $time, flush, exp_flush);
            errors = errors + 1;
        end
    target_chk: assert property (@(negedge clk) disable iff (!resetn)
                                 !exp_flush || flush_target == exp_target)
        else begin
            $display("MISMATCH %0t: flush_target %h, expected %h", $time, flush_target, exp_target);
            errors = errors + 1;
        end
    trace_chk: assert property (@(negedge clk) disable iff (!resetn)
                                trace_we == {4{exp_we}} && (!exp_we || (trace_pc == hold_pkt.pc
                                && trace_wnum == hold_pkt.rf_waddr && trace_wdata == exp_wdata)))
        else begin
            $display("MISMATCH %0t: trace we %h r%0d = %h, expected we %b r%0d = %h", $time,
                     trace_we, trace_wnum, trace_wdata, exp_we, hold_pkt.rf_waddr, exp_wdata);
            errors = errors + 1;
        end
    fwd_chk: assert property (@(negedge clk) disable iff (!resetn)
                              wb_fwd.we == exp_we && (!exp_we || (wb_fwd.waddr == hold_pkt.rf_waddr
                              && wb_fwd.wdata == exp_wdata)))
        else begin
            $display("MISMATCH %0t: wb_fwd we %b r%0d = %h", $time, wb_fwd.we, wb_fwd.waddr,
                     wb_fwd.wdata);
            errors = errors + 1;
        end
    read_chk: assert property (@(negedge clk) disable iff (!resetn) rd1_ok && rd2_ok)
        else begin
            $display("MISMATCH %0t: r%0d reads %h, r%0d reads %h", $time, raddr1, rdata1,
                     raddr2, rdata2);
            errors = errors + 1;
        end

    function automatic mem_to_wb_t plain_pkt(input logic [4:0] rd, input logic [31:0] data,
                                             input logic [31:0] pc);
        mem_to_wb_t p;
        p = '0;
        p.rf_we    = 1'b1;
        p.rf_waddr = rd;
        p.rf_wdata = data;
        p.pc       = pc;
        return p;
    endfunction

    // csrrd, csrwr and csrxchg all return the old value
    function automatic mem_to_wb_t csr_pkt(input logic [4:0] rd, input logic [13:0] num,
                                           input logic we, input logic [31:0] mask,
                                           input logic [31:0] value);
        mem_to_wb_t p;
        p = '0;
        p.rf_we      = (rd != 5'd0);
        p.rf_waddr   = rd;
        p.pc         = 32'h1c00_0100;
        p.csr_re     = 1'b1;
        p.csr_we     = we;
        p.csr_num    = num;
        p.csr_wmask  = mask;
        p.csr_wvalue = value;
        return p;
    endfunction

    task automatic report_and_finish();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic drive(input logic v, input mem_to_wb_t p);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = $random(seed);
        in_valid = v;
        in_pkt   = p;
        raddr1   = r[4:0];
        raddr2   = r[12:8];
    endtask

    task automatic send(input mem_to_wb_t p);
        drive(1'b1, p);
    endtask

    // stop offering packets and wait for the stage to go empty
    task automatic wait_quiet(input int max_cycles);
        int n;
        n = 0;
        drive(1'b0, '0);     // last offered packet enters the stage at this edge
        while ((flush || trace_we != 4'h0) && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (flush || trace_we != 4'h0) begin
            $display("timeout: the stage did not drain within %0d cycles", max_cycles);
            errors = errors + 1;
            report_and_finish();
        end
    endtask

    task automatic take_exception(input logic [5:0] flags, input logic [31:0] pc);
        mem_to_wb_t  p;
        logic [31:0] r;
        r = $random(seed);
        p = plain_pkt(5'd8, r, pc);
        p.excep      = {1'b1, flags};
        p.esubcode   = r[8:0];
        p.csr_we     = 1'b1;               // must not reach SAVE1
        p.csr_num    = csr_save1;
        p.csr_wmask  = 32'hffff_ffff;
        p.csr_wvalue = ~r;
        send(p);
        send(plain_pkt(5'd9, 32'hdead_0000 ^ r, pc + 32'h4));   // offered during the flush
    endtask

    initial begin
        int          i;
        logic [31:0] r, d, a;
        logic [5:0]  flags;
        mem_to_wb_t  p;

        seed     = 32'h992c_34ef;
        errors   = 0;
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_pkt   = '0;
        raddr1   = 5'd0;
        raddr2   = 5'd0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // reset values and the handler address
        send(csr_pkt(5'd1, csr_crmd, 1'b0, 32'h0, 32'h0));
        send(csr_pkt(5'd2, csr_eentry, 1'b1, 32'hffff_ffff, 32'h1c00_1234));
        send(csr_pkt(5'd3, csr_eentry, 1'b0, 32'h0, 32'h0));
        wait_quiet(8);

        for (i = 0; i < 200; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = $random(seed);
            p = plain_pkt(r[4:0], d, a);
            p.rf_we = r[5] | r[6];
            drive(r[8:7] != 2'b00, p);
        end
        wait_quiet(8);

        // masked csr writes
        for (i = 0; i < 4; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = $random(seed);
            send(csr_pkt(5'd4, 14'h30 + 14'(i), 1'b1, 32'hffff_ffff, r));
            send(csr_pkt(5'd5, 14'h30 + 14'(i), 1'b1, d, a));      // csrxchg
            send(csr_pkt(5'd6, 14'h30 + 14'(i), 1'b0, 32'h0, 32'h0));
        end
        send(csr_pkt(5'd4, csr_crmd, 1'b1, 32'hffff_ffff, 32'hffff_ffff));
        send(csr_pkt(5'd5, csr_crmd, 1'b0, 32'h0, 32'h0));
        send(csr_pkt(5'd0, csr_crmd, 1'b1, 32'hffff_ffff, 32'h0000_0008));

        // rdcntid
        r = $random(seed);
        send(csr_pkt(5'd0, csr_tid, 1'b1, 32'hffff_ffff, r));
        p = plain_pkt(5'd7, 32'h0, 32'h1c00_0200);
        p.read_tid = 1'b1;
        send(p);
        wait_quiet(8);

        // each flag alone, then random combinations
        for (i = 0; i < 12; i++) begin
            r = $random(seed);
            flags = (i < 6) ? (6'b000001 << i) : r[13:8];
            if (flags == 6'b0) flags = 6'b100000;
            send(csr_pkt(5'd0, csr_crmd, 1'b1, 32'h7, r));    // random plv and ie
            take_exception(flags, {r[31:2], 2'b00});
            send(csr_pkt(5'd10, csr_estat, 1'b0, 32'h0, 32'h0));
            send(csr_pkt(5'd11, csr_era, 1'b0, 32'h0, 32'h0));
            send(csr_pkt(5'd12, csr_prmd, 1'b0, 32'h0, 32'h0));
            send(csr_pkt(5'd13, csr_save1, 1'b0, 32'h0, 32'h0));
            wait_quiet(8);
        end

        // ertn brings back plv and ie
        send(csr_pkt(5'd0, csr_crmd, 1'b1, 32'h7, 32'h7));
        take_exception(6'b000100, 32'h1c00_0400);
        send(csr_pkt(5'd14, csr_prmd, 1'b0, 32'h0, 32'h0));
        p = plain_pkt(5'd0, 32'h0, 32'h1c00_1200);
        p.rf_we = 1'b0;
        p.ertn  = 1'b1;
        send(p);
        send(plain_pkt(5'd16, 32'hbad0_0001, 32'h1c00_1204));  // dropped by the ertn flush
        send(csr_pkt(5'd15, csr_crmd, 1'b0, 32'h0, 32'h0));
        wait_quiet(8);

        report_and_finish();
    end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                    clk,
    input  logic                    resetn,
    input  wb_pkg::csr_req_t        csr_req,
    output logic [wb_pkg::xlen-1:0] csr_rvalue,
    input  wb_pkg::excep_req_t      excep_req,
    input  logic                    ertn,
    input  logic [wb_pkg::xlen-1:0] ex_pc,
    output logic [wb_pkg::xlen-1:0] flush_target
);
    import wb_pkg::*;

    logic [xlen-1:0] crmd;
    logic [xlen-1:0] prmd;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] era;
    logic [xlen-1:0] eentry;
    logic [xlen-1:0] save0;
    logic [xlen-1:0] save1;
    logic [xlen-1:0] save2;
    logic [xlen-1:0] save3;
    logic [xlen-1:0] tid;

    logic [xlen-1:0] rd_value;

    // merge wvalue under wmask, restricted to the writable field
    function automatic logic [xlen-1:0] merge(
        input logic [xlen-1:0] old,
        input logic [xlen-1:0] field
    );
        logic [xlen-1:0] m;
        m = csr_req.wmask & field;
        return (old & ~m) | (csr_req.wvalue & m);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd   <= crmd_reset;
            prmd   <= '0;
            estat  <= '0;
            era    <= '0;
            eentry <= '0;
            save0  <= '0;
            save1  <= '0;
            save2  <= '0;
            save3  <= '0;
            tid    <= '0;
        end else if (excep_req.ex) begin
            // exception entry wins over the instruction's own csr write
            prmd[2]       <= crmd[2];     // pie
            prmd[1:0]     <= crmd[1:0];   // pplv
            crmd[2:0]     <= 3'b000;      // kernel, interrupts off
            estat[21:16]  <= excep_req.ecode;
            estat[30:22]  <= excep_req.esubcode;
            era           <= ex_pc;
        end else if (ertn) begin
            crmd[2:0] <= prmd[2:0];       // restore ie and plv
        end else if (csr_req.we) begin
            case (csr_req.num)
                csr_crmd:   crmd   <= merge(crmd, crmd_wr_mask);
                csr_prmd:   prmd   <= merge(prmd, prmd_wr_mask);
                csr_estat:  estat  <= merge(estat, estat_wr_mask);  // swi bits only
                csr_era:    era    <= merge(era, era_wr_mask);
                csr_eentry: eentry <= merge(eentry, eentry_wr_mask);
                csr_save0:  save0  <= merge(save0, save_wr_mask);
                csr_save1:  save1  <= merge(save1, save_wr_mask);
                csr_save2:  save2  <= merge(save2, save_wr_mask);
                csr_save3:  save3  <= merge(save3, save_wr_mask);
                csr_tid:    tid    <= merge(tid, tid_wr_mask);
                default:    ;                                     // unknown number
            endcase
        end
    end

    // read decode
    always_comb begin
        case (csr_req.num)
            csr_crmd:   rd_value = crmd;
            csr_prmd:   rd_value = prmd;
            csr_estat:  rd_value = estat;
            csr_era:    rd_value = era;
            csr_eentry: rd_value = eentry;
            csr_save0:  rd_value = save0;
            csr_save1:  rd_value = save1;
            csr_save2:  rd_value = save2;
            csr_save3:  rd_value = save3;
            csr_tid:    rd_value = tid;
            default:    rd_value = '0;
        endcase
    end

    assign csr_rvalue = csr_req.re ? rd_value : '0;

    // exception goes to the handler, ertn back to era
    assign flush_target = excep_req.ex ? eentry : era;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  wb_pkg::rf_write_t             rf_write,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr2,
    output logic [wb_pkg::xlen-1:0]       rdata1,
    output logic [wb_pkg::xlen-1:0]       rdata2
);
    import wb_pkg::*;

    logic [xlen-1:0] regs [rf_depth];

    // single write port, r0 is never written
    always_ff @(posedge clk) begin
        if (rf_write.we && rf_write.waddr != '0) begin
            regs[rf_write.waddr] <= rf_write.wdata;
        end
    end

    // async reads, r0 hardwired to zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/wb_backend_top.sv
`timescale 1ns/1ps

module wb_backend_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    input  wb_pkg::mem_to_wb_t            in_pkt,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr2,
    output logic [wb_pkg::xlen-1:0]       rdata1,
    output logic [wb_pkg::xlen-1:0]       rdata2,
    output wb_pkg::rf_write_t             wb_fwd,
    output logic [wb_pkg::xlen-1:0]       trace_pc,
    output logic [3:0]                    trace_we,
    output logic [wb_pkg::reg_addr_w-1:0] trace_wnum,
    output logic [wb_pkg::xlen-1:0]       trace_wdata,
    output logic                          flush,
    output logic [wb_pkg::xlen-1:0]       flush_target
);
    import wb_pkg::*;

    csr_req_t        csr_req;
    excep_req_t      excep_req;
    rf_write_t       rf_write;
    logic            ertn;
    logic [xlen-1:0] csr_rvalue;

    wb_stage u_wb_stage (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .csr_rvalue (csr_rvalue),
        .csr_req    (csr_req),
        .excep_req  (excep_req),
        .ertn       (ertn),
        .rf_write   (rf_write),
        .trace_pc   (trace_pc)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .resetn       (resetn),
        .csr_req      (csr_req),
        .csr_rvalue   (csr_rvalue),
        .excep_req    (excep_req),
        .ertn         (ertn),
        .ex_pc        (trace_pc),      // pc of the instruction in writeback
        .flush_target (flush_target)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rf_write (rf_write),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .rdata1   (rdata1),
        .rdata2   (rdata2)
    );

    // forwarding and trace see the same write
    assign wb_fwd      = rf_write;
    assign trace_we    = {4{rf_write.we}};
    assign trace_wnum  = rf_write.waddr;
    assign trace_wdata = rf_write.wdata;

    assign flush = excep_req.ex | ertn;

endmodule

// File: hdl/wb_pkg.sv
package wb_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int rf_depth   = 1 << reg_addr_w;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // software writable bits per csr
    localparam logic [xlen-1:0] crmd_wr_mask   = 32'h0000_01ff;
    localparam logic [xlen-1:0] prmd_wr_mask   = 32'h0000_0007;
    localparam logic [xlen-1:0] estat_wr_mask  = 32'h0000_0003;
    localparam logic [xlen-1:0] era_wr_mask    = 32'hffff_ffff;
    localparam logic [xlen-1:0] eentry_wr_mask = 32'hffff_ffc0;
    localparam logic [xlen-1:0] save_wr_mask   = 32'hffff_ffff;
    localparam logic [xlen-1:0] tid_wr_mask    = 32'hffff_ffff;

    localparam logic [xlen-1:0] crmd_reset = 32'h0000_0008;  // plv 0, da 1

    typedef enum logic [csr_num_w-1:0] {
        csr_crmd   = 14'h00,
        csr_prmd   = 14'h01,
        csr_estat  = 14'h05,
        csr_era    = 14'h06,
        csr_eentry = 14'h0c,
        csr_save0  = 14'h30,
        csr_save1  = 14'h31,
        csr_save2  = 14'h32,
        csr_save3  = 14'h33,
        csr_tid    = 14'h40
    } csr_num_e;

    typedef enum logic [ecode_w-1:0] {
        ec_int  = 6'h00,
        ec_adef = 6'h08,
        ec_ale  = 6'h09,
        ec_sys  = 6'h0b,
        ec_brk  = 6'h0c,
        ec_ine  = 6'h0d
    } ecode_e;

    typedef struct packed {
        logic any;      // summary, set by earlier stages
        logic intr;
        logic adef;
        logic syscall;
        logic brk;
        logic ine;
        logic ale;
    } excep_t;

    // one retiring instruction from the memory stage
    typedef struct packed {
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
        logic [xlen-1:0]       rf_wdata;
        logic [xlen-1:0]       pc;
        logic                  read_tid;   // rdcntid
        logic                  csr_re;
        logic                  csr_we;
        logic [csr_num_w-1:0]  csr_num;
        logic [xlen-1:0]       csr_wmask;
        logic [xlen-1:0]       csr_wvalue;
        logic                  ertn;
        excep_t                excep;
        logic [esubcode_w-1:0] esubcode;
    } mem_to_wb_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic                 re;
        logic                 we;
        logic [csr_num_w-1:0] num;
        logic [xlen-1:0]      wmask;
        logic [xlen-1:0]      wvalue;
    } csr_req_t;

    typedef struct packed {
        logic                  ex;
        ecode_e                ecode;
        logic [esubcode_w-1:0] esubcode;
    } excep_req_t;

endpackage

// File: hdl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   in_valid,
    input  wb_pkg::mem_to_wb_t     in_pkt,
    input  logic [wb_pkg::xlen-1:0] csr_rvalue,
    output wb_pkg::csr_req_t       csr_req,
    output wb_pkg::excep_req_t     excep_req,
    output logic                   ertn,
    output wb_pkg::rf_write_t      rf_write,
    output logic [wb_pkg::xlen-1:0] trace_pc
);
    import wb_pkg::*;

    logic       valid;
    mem_to_wb_t pkt;
    logic       ex;
    logic       flush;
    logic       csr_to_rf;   // result comes from the csr read port
    ecode_e     ecode;

    assign ex    = valid & pkt.excep.any;
    assign ertn  = valid & pkt.ertn;
    assign flush = ex | ertn;

    // never stalls, so a valid packet is always taken unless we are flushing
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;     // drop the younger packet
        end else begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !flush) begin
            pkt <= in_pkt;
        end
    end

    // fixed priority, interrupt first
    always_comb begin
        if (pkt.excep.intr) begin
            ecode = ec_int;
        end else if (pkt.excep.adef) begin
            ecode = ec_adef;
        end else if (pkt.excep.syscall) begin
            ecode = ec_sys;
        end else if (pkt.excep.brk) begin
            ecode = ec_brk;
        end else if (pkt.excep.ine) begin
            ecode = ec_ine;
        end else begin
            ecode = ec_ale;    // ale or summary bit alone
        end
    end

    assign excep_req.ex       = ex;
    assign excep_req.ecode    = ecode;
    assign excep_req.esubcode = pkt.esubcode;

    // csr access, rdcntid goes through the tid register
    assign csr_to_rf      = pkt.csr_re | pkt.read_tid;
    assign csr_req.re     = csr_to_rf;
    assign csr_req.we     = valid & pkt.csr_we;
    assign csr_req.num    = pkt.read_tid ? csr_tid : pkt.csr_num;
    assign csr_req.wmask  = pkt.csr_wmask;
    assign csr_req.wvalue = pkt.csr_wvalue;

    // excepting instruction does not retire a result
    assign rf_write.we    = valid & pkt.rf_we & ~pkt.excep.any;
    assign rf_write.waddr = pkt.rf_waddr;
    assign rf_write.wdata = csr_to_rf ? csr_rvalue : pkt.rf_wdata;

    assign trace_pc = pkt.pc;  // also the exception pc

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compile and run the writeback back end testbench with Verilator.
# Exits non-zero when the build or run fails, or when the log reports failure.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_tb_wb_backend
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_wb_backend \
    -f src.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi

echo "testbench run finished without failure"
exit 0

// File: src.f
hdl/wb_pkg.sv
hdl/csr_file.sv
hdl/reg_file.sv
hdl/wb_stage.sv
hdl/wb_backend_top.sv
dv/tb_wb_backend.sv
